/* Bender.yml */
package:
  name: addrgen

export_include_dirs:
  - source

sources:
  - source/addrgen_pkg.sv
  - source/addrgen_apb_regs.sv
  - source/addrgen_loop_nest.sv
  - source/addrgen_out_buf.sv
  - source/addrgen_top.sv
  - target: test
    files:
      - verification/tb_addrgen.sv

/* source/addrgen_apb_regs.sv */
// apb slave with configuration registers, ctrl pulses and sticky done status
`timescale 1ns/1ps
`default_nettype none

`include "addrgen_consts.svh"

module addrgen_apb_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // apb slave
  input  logic                    apb_psel_i,
  input  logic                    apb_penable_i,
  input  logic                    apb_pwrite_i,
  input  logic [`ADDRGEN_PAW-1:0] apb_paddr_i,
  input  logic [`ADDRGEN_AW-1:0]  apb_pwdata_i,
  output logic [`ADDRGEN_AW-1:0]  apb_prdata_o,
  output logic                    apb_pready_o,
  output logic                    apb_pslverr_o,
  // configuration towards the loop nest
  output addrgen_pkg::addr_t      base_o,
  output addrgen_pkg::cnt_t       tot_len_o,
  output addrgen_pkg::cnt_t       d0_len_o,
  output addrgen_pkg::cnt_t       d1_len_o,
  output addrgen_pkg::cnt_t       d2_len_o,
  output addrgen_pkg::stride_t    d0_stride_o,
  output addrgen_pkg::stride_t    d1_stride_o,
  output addrgen_pkg::stride_t    d2_stride_o,
  output addrgen_pkg::stride_t    d3_stride_o,
  output addrgen_pkg::dim_en_t    dim_en_o,
  output logic                    start_o,   // one-cycle pulse
  output logic                    clear_o,   // one-cycle pulse
  input  logic                    busy_i,
  input  logic                    done_i     // one-cycle pulse from the loop nest
);

  import addrgen_pkg::*;

  logic                   access;   // apb access phase
  logic                   mapped;   // offset decodes to some register
  logic                   is_cfg;   // offset is a configuration register
  logic                   ctrl_wr;
  logic                   cfg_wr;
  logic [`ADDRGEN_AW-1:0] rdata;
  logic                   done_q;   // sticky done

  addr_t   base_q;
  cnt_t    tot_len_q;
  cnt_t    d0_len_q;
  cnt_t    d1_len_q;
  cnt_t    d2_len_q;
  stride_t d0_stride_q;
  stride_t d1_stride_q;
  stride_t d2_stride_q;
  stride_t d3_stride_q;
  dim_en_t dim_en_q;

  assign access       = apb_psel_i & apb_penable_i;
  assign apb_pready_o = 1'b1; // zero wait states

  // offset decode and read mux
  always_comb begin
    rdata  = '0;
    mapped = 1'b1;
    is_cfg = 1'b1;
    case (apb_paddr_i)
      `ADDRGEN_REG_CTRL:      is_cfg = 1'b0; // command bits read as zero
      `ADDRGEN_REG_STATUS: begin
        is_cfg = 1'b0; // read-only so writes are dropped
        rdata[`ADDRGEN_STATUS_BUSY_BIT] = busy_i;
        rdata[`ADDRGEN_STATUS_DONE_BIT] = done_q;
      end
      `ADDRGEN_REG_BASE:      rdata = base_q;
      `ADDRGEN_REG_TOT_LEN:   rdata = tot_len_q;
      `ADDRGEN_REG_D0_LEN:    rdata = d0_len_q;
      `ADDRGEN_REG_D1_LEN:    rdata = d1_len_q;
      `ADDRGEN_REG_D2_LEN:    rdata = d2_len_q;
      `ADDRGEN_REG_D0_STRIDE: rdata = d0_stride_q;
      `ADDRGEN_REG_D1_STRIDE: rdata = d1_stride_q;
      `ADDRGEN_REG_D2_STRIDE: rdata = d2_stride_q;
      `ADDRGEN_REG_D3_STRIDE: rdata = d3_stride_q;
      `ADDRGEN_REG_DIM_EN:    rdata = `ADDRGEN_AW'(dim_en_q);
      default: begin
        mapped = 1'b0;
        is_cfg = 1'b0;
      end
    endcase
  end

  assign apb_prdata_o  = rdata;
  // unmapped offset or config write during a run
  assign apb_pslverr_o = access & (~mapped | (apb_pwrite_i & is_cfg & busy_i));

  assign cfg_wr  = access & apb_pwrite_i & is_cfg & ~busy_i;
  assign ctrl_wr = access & apb_pwrite_i & (apb_paddr_i == `ADDRGEN_REG_CTRL);

  // clear has priority and start only leaves idle
  assign clear_o = ctrl_wr & apb_pwdata_i[`ADDRGEN_CTRL_CLEAR_BIT];
  assign start_o = ctrl_wr & apb_pwdata_i[`ADDRGEN_CTRL_START_BIT]
                 & ~apb_pwdata_i[`ADDRGEN_CTRL_CLEAR_BIT] & ~busy_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q      <= `ADDRGEN_CFG_RESET;
      tot_len_q   <= `ADDRGEN_CFG_RESET;
      d0_len_q    <= `ADDRGEN_CFG_RESET;
      d1_len_q    <= `ADDRGEN_CFG_RESET;
      d2_len_q    <= `ADDRGEN_CFG_RESET;
      d0_stride_q <= `ADDRGEN_CFG_RESET;
      d1_stride_q <= `ADDRGEN_CFG_RESET;
      d2_stride_q <= `ADDRGEN_CFG_RESET;
      d3_stride_q <= `ADDRGEN_CFG_RESET;
      dim_en_q    <= `ADDRGEN_DIM_EN_RESET;
    end else if (cfg_wr) begin
      case (apb_paddr_i)
        `ADDRGEN_REG_BASE:      base_q      <= addr_t'(apb_pwdata_i);
        `ADDRGEN_REG_TOT_LEN:   tot_len_q   <= cnt_t'(apb_pwdata_i);
        `ADDRGEN_REG_D0_LEN:    d0_len_q    <= cnt_t'(apb_pwdata_i);
        `ADDRGEN_REG_D1_LEN:    d1_len_q    <= cnt_t'(apb_pwdata_i);
        `ADDRGEN_REG_D2_LEN:    d2_len_q    <= cnt_t'(apb_pwdata_i);
        `ADDRGEN_REG_D0_STRIDE: d0_stride_q <= stride_t'(apb_pwdata_i);
        `ADDRGEN_REG_D1_STRIDE: d1_stride_q <= stride_t'(apb_pwdata_i);
        `ADDRGEN_REG_D2_STRIDE: d2_stride_q <= stride_t'(apb_pwdata_i);
        `ADDRGEN_REG_D3_STRIDE: d3_stride_q <= stride_t'(apb_pwdata_i);
        `ADDRGEN_REG_DIM_EN:    dim_en_q    <= dim_en_t'(apb_pwdata_i);
        default: ;
      endcase
    end
  end

  // done stays set until the next start or clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (start_o || clear_o) begin
      done_q <= 1'b0;
    end else if (done_i) begin
      done_q <= 1'b1;
    end
  end

  assign base_o      = base_q;
  assign tot_len_o   = tot_len_q;
  assign d0_len_o    = d0_len_q;
  assign d1_len_o    = d1_len_q;
  assign d2_len_o    = d2_len_q;
  assign d0_stride_o = d0_stride_q;
  assign d1_stride_o = d1_stride_q;
  assign d2_stride_o = d2_stride_q;
  assign d3_stride_o = d3_stride_q;
  assign dim_en_o    = dim_en_q;

  // a start pulse brings the loop nest out of idle
  a_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_o |=> busy_i)
    else $error("start not followed by busy");

endmodule

`default_nettype wire

/* source/addrgen_consts.svh */
// widths, apb register offsets, command and status bits, register reset values
`ifndef ADDRGEN_CONSTS_SVH
`define ADDRGEN_CONSTS_SVH

// datapath widths
`define ADDRGEN_AW  32 // byte address and apb data
`define ADDRGEN_CW  32 // overall and dimension counters
`define ADDRGEN_PAW 12 // apb address

// register byte offsets
`define ADDRGEN_REG_CTRL      12'h000
`define ADDRGEN_REG_STATUS    12'h004
`define ADDRGEN_REG_BASE      12'h008
`define ADDRGEN_REG_TOT_LEN   12'h00C
`define ADDRGEN_REG_D0_LEN    12'h010
`define ADDRGEN_REG_D1_LEN    12'h014
`define ADDRGEN_REG_D2_LEN    12'h018
`define ADDRGEN_REG_D0_STRIDE 12'h01C
`define ADDRGEN_REG_D1_STRIDE 12'h020
`define ADDRGEN_REG_D2_STRIDE 12'h024
`define ADDRGEN_REG_D3_STRIDE 12'h028
`define ADDRGEN_REG_DIM_EN    12'h02C

// ctrl command bits, write-one
`define ADDRGEN_CTRL_START_BIT 0
`define ADDRGEN_CTRL_CLEAR_BIT 1

// status bits
`define ADDRGEN_STATUS_BUSY_BIT 0
`define ADDRGEN_STATUS_DONE_BIT 1

// reset values of the configuration registers
`define ADDRGEN_CFG_RESET    32'h0000_0000
`define ADDRGEN_DIM_EN_RESET 3'b000

`endif

/* source/addrgen_loop_nest.sv */
// four-level counter and stride stepping that issues byte addresses
`timescale 1ns/1ps
`default_nettype none

module addrgen_loop_nest (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  logic                 clear_i,
  // configuration held stable while busy
  input  addrgen_pkg::addr_t   base_i,
  input  addrgen_pkg::cnt_t    tot_len_i,
  input  addrgen_pkg::cnt_t    d0_len_i,
  input  addrgen_pkg::cnt_t    d1_len_i,
  input  addrgen_pkg::cnt_t    d2_len_i,
  input  addrgen_pkg::stride_t d0_stride_i,
  input  addrgen_pkg::stride_t d1_stride_i,
  input  addrgen_pkg::stride_t d2_stride_i,
  input  addrgen_pkg::stride_t d3_stride_i,
  input  addrgen_pkg::dim_en_t dim_en_i,
  // item stream towards the output buffer
  output addrgen_pkg::addr_t   item_addr_o,
  output logic                 item_valid_o,
  input  logic                 item_ready_i,
  // status
  output logic                 busy_o,
  output logic                 done_o
);

  import addrgen_pkg::*;

  logic  running_q;
  logic  done_q;      // pulse one cycle after the run ends
  logic  accept;      // item taken by the buffer
  logic  last_item;
  logic  finish;

  // dimension offsets relative to base
  addr_t d0_addr_q, d0_addr_d;
  addr_t d1_addr_q, d1_addr_d;
  addr_t d2_addr_q, d2_addr_d;
  addr_t d3_addr_q, d3_addr_d;

  // d3 has no length and never wraps
  cnt_t  d0_cnt_q, d0_cnt_d;
  cnt_t  d1_cnt_q, d1_cnt_d;
  cnt_t  d2_cnt_q, d2_cnt_d;
  cnt_t  ov_cnt_q;    // addresses issued so far
  cnt_t  ov_cnt_inc;

  assign item_valid_o = running_q & (ov_cnt_q != tot_len_i);
  assign accept       = item_valid_o & item_ready_i;
  assign ov_cnt_inc   = ov_cnt_q + cnt_t'(1);
  assign last_item    = accept & (ov_cnt_inc == tot_len_i);
  // second term covers tot_len of zero
  assign finish       = running_q & (last_item | (ov_cnt_q == tot_len_i));

  assign item_addr_o = base_i + d0_addr_q + d1_addr_q + d2_addr_q + d3_addr_q;

  // next dimension state where the first matching level steps
  always_comb begin
    d0_addr_d = d0_addr_q;
    d1_addr_d = d1_addr_q;
    d2_addr_d = d2_addr_q;
    d3_addr_d = d3_addr_q;
    d0_cnt_d  = d0_cnt_q;
    d1_cnt_d  = d1_cnt_q;
    d2_cnt_d  = d2_cnt_q;
    if ((d0_cnt_q < d0_len_i) || !dim_en_i[0]) begin
      d0_addr_d = d0_addr_q + addr_t'(d0_stride_i);
      d0_cnt_d  = d0_cnt_q + cnt_t'(1);
    end else if ((d1_cnt_q < d1_len_i) || !dim_en_i[1]) begin
      d0_addr_d = '0;
      d0_cnt_d  = cnt_t'(1);
      d1_addr_d = d1_addr_q + addr_t'(d1_stride_i);
      d1_cnt_d  = d1_cnt_q + cnt_t'(1);
    end else if ((d2_cnt_q < d2_len_i) || !dim_en_i[2]) begin
      d0_addr_d = '0;
      d1_addr_d = '0;
      d0_cnt_d  = cnt_t'(1);
      d1_cnt_d  = cnt_t'(1);
      d2_addr_d = d2_addr_q + addr_t'(d2_stride_i);
      d2_cnt_d  = d2_cnt_q + cnt_t'(1);
    end else begin
      // all inner levels wrapped so the outer dimension steps
      d0_addr_d = '0;
      d1_addr_d = '0;
      d2_addr_d = '0;
      d0_cnt_d  = cnt_t'(1);
      d1_cnt_d  = cnt_t'(1);
      d2_cnt_d  = cnt_t'(1);
      d3_addr_d = d3_addr_q + addr_t'(d3_stride_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
      d0_addr_q <= '0;
      d1_addr_q <= '0;
      d2_addr_q <= '0;
      d3_addr_q <= '0;
      d0_cnt_q  <= cnt_t'(1);
      d1_cnt_q  <= cnt_t'(1);
      d2_cnt_q  <= cnt_t'(1);
      ov_cnt_q  <= '0;
    end else if (clear_i) begin
      running_q <= 1'b0; // back to idle with counters reloaded on start
      done_q    <= 1'b0;
    end else if (start_i) begin
      running_q <= 1'b1;
      done_q    <= 1'b0;
      d0_addr_q <= '0;
      d1_addr_q <= '0;
      d2_addr_q <= '0;
      d3_addr_q <= '0;
      d0_cnt_q  <= cnt_t'(1);
      d1_cnt_q  <= cnt_t'(1);
      d2_cnt_q  <= cnt_t'(1);
      ov_cnt_q  <= '0;
    end else begin
      done_q <= finish;
      if (finish) begin
        running_q <= 1'b0;
      end
      if (accept) begin // frozen under back-pressure
        d0_addr_q <= d0_addr_d;
        d1_addr_q <= d1_addr_d;
        d2_addr_q <= d2_addr_d;
        d3_addr_q <= d3_addr_d;
        d0_cnt_q  <= d0_cnt_d;
        d1_cnt_q  <= d1_cnt_d;
        d2_cnt_q  <= d2_cnt_d;
        ov_cnt_q  <= ov_cnt_inc;
      end
    end
  end

  assign busy_o = running_q;
  assign done_o = done_q;

  // issue count never runs past tot_len during a run
  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_o |-> (ov_cnt_q <= tot_len_i))
    else $error("issue count exceeded tot_len");

endmodule

`default_nettype wire

/* source/addrgen_out_buf.sv */
// two-entry registered valid/ready buffer on the address stream
`timescale 1ns/1ps
`default_nettype none

module addrgen_out_buf (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,      // drops both entries
  // from the loop nest
  input  addrgen_pkg::addr_t in_addr_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  // address stream
  output addrgen_pkg::addr_t addr_o,
  output logic               addr_valid_o,
  input  logic               addr_ready_i
);

  import addrgen_pkg::*;

  logic  head_valid_q;   // entry driving the stream
  logic  tail_valid_q;   // overflow entry set only on a stall
  addr_t head_q;
  addr_t tail_q;
  logic  push;
  logic  pop;

  // ready depends on state only and not on addr_ready_i
  assign in_ready_o = ~tail_valid_q;
  assign push       = in_valid_i & in_ready_o;
  assign pop        = head_valid_q & addr_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_valid_q <= 1'b0;
      tail_valid_q <= 1'b0;
    end else if (clear_i) begin
      head_valid_q <= 1'b0;
      tail_valid_q <= 1'b0;
    end else if (pop) begin
      if (tail_valid_q) begin
        tail_valid_q <= 1'b0;  // tail moves up and head stays valid
      end else begin
        head_valid_q <= push;  // pass-through at full rate
      end
    end else if (push) begin
      if (head_valid_q) begin
        tail_valid_q <= 1'b1;
      end else begin
        head_valid_q <= 1'b1;
      end
    end
  end

  // payload path
  always_ff @(posedge clk_i) begin
    if (pop && tail_valid_q) begin
      head_q <= tail_q;
    end else if (push && (pop || !head_valid_q)) begin
      head_q <= in_addr_i;
    end else if (push) begin
      tail_q <= in_addr_i;
    end
  end

  assign addr_o       = head_q;
  assign addr_valid_o = head_valid_q;

  // overflow entry only ever sits behind a valid head
  a_tail_behind_head: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tail_valid_q |-> head_valid_q)
    else $error("overflow entry held without a head entry");

  // stream rule holds until the transfer unless cleared
  a_stream_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (addr_valid_o && !addr_ready_i && !clear_i) |=> (addr_valid_o && $stable(addr_o)))
    else $error("address changed or dropped under back-pressure");

endmodule

`default_nettype wire

/* source/addrgen_pkg.sv */
// addrgen_pkg: address, counter, stride and dimension mask types
`default_nettype none

`include "addrgen_consts.svh"

package addrgen_pkg;

  // byte address on the stream, wraps modulo 2^AW
  typedef logic [`ADDRGEN_AW-1:0] addr_t;

  // transaction count, used for tot_len, the dimension lengths
  // and all internal counters
  typedef logic [`ADDRGEN_CW-1:0] cnt_t;

  // byte stride per dimension, two's complement so a dimension can walk backwards
  typedef logic signed [`ADDRGEN_AW-1:0] stride_t;

  // bit k enables the wrap of dimension k
  // 000 -> 1-d stream on d0 only
  // 001 -> d0 wraps into d1
  // 011 -> d0, d1 wrap into d2
  // 111 -> full 4-d nest, d2 wraps into d3
  typedef logic [2:0] dim_en_t;

endpackage

`default_nettype wire

/* source/addrgen_top.sv */
// addrgen_top: apb registers, loop nest and output buffer of the strided address generator
`timescale 1ns/1ps
`default_nettype none

`include "addrgen_consts.svh"

module addrgen_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // apb slave
  input  logic                    apb_psel_i,
  input  logic                    apb_penable_i,
  input  logic                    apb_pwrite_i,
  input  logic [`ADDRGEN_PAW-1:0] apb_paddr_i,
  input  logic [`ADDRGEN_AW-1:0]  apb_pwdata_i,
  output logic [`ADDRGEN_AW-1:0]  apb_prdata_o,
  output logic                    apb_pready_o,
  output logic                    apb_pslverr_o,
  // address stream
  output addrgen_pkg::addr_t      addr_o,
  output logic                    addr_valid_o,
  input  logic                    addr_ready_i
);

  import addrgen_pkg::*;

  addr_t   base;
  cnt_t    tot_len, d0_len, d1_len, d2_len;
  stride_t d0_stride, d1_stride, d2_stride, d3_stride;
  dim_en_t dim_en;
  logic    start, clear, busy, done;
  addr_t   item_addr;
  logic    item_valid, item_ready;

  addrgen_apb_regs u_apb_regs (
    .clk_i, .rst_ni,
    .apb_psel_i, .apb_penable_i, .apb_pwrite_i, .apb_paddr_i, .apb_pwdata_i,
    .apb_prdata_o, .apb_pready_o, .apb_pslverr_o,
    .base_o(base), .tot_len_o(tot_len),
    .d0_len_o(d0_len), .d1_len_o(d1_len), .d2_len_o(d2_len),
    .d0_stride_o(d0_stride), .d1_stride_o(d1_stride),
    .d2_stride_o(d2_stride), .d3_stride_o(d3_stride),
    .dim_en_o(dim_en), .start_o(start), .clear_o(clear),
    .busy_i(busy), .done_i(done)
  );

  addrgen_loop_nest u_loop_nest (
    .clk_i, .rst_ni, .start_i(start), .clear_i(clear),
    .base_i(base), .tot_len_i(tot_len),
    .d0_len_i(d0_len), .d1_len_i(d1_len), .d2_len_i(d2_len),
    .d0_stride_i(d0_stride), .d1_stride_i(d1_stride),
    .d2_stride_i(d2_stride), .d3_stride_i(d3_stride),
    .dim_en_i(dim_en),
    .item_addr_o(item_addr), .item_valid_o(item_valid), .item_ready_i(item_ready),
    .busy_o(busy), .done_o(done)
  );

  addrgen_out_buf u_out_buf (
    .clk_i, .rst_ni, .clear_i(clear),
    .in_addr_i(item_addr), .in_valid_i(item_valid), .in_ready_o(item_ready),
    .addr_o, .addr_valid_o, .addr_ready_i
  );

endmodule

`default_nettype wire

/* verification/tb_addrgen.sv */
// testbench top with apb driver, stream monitor, reference model, test table and clear run
`timescale 1ns/1ps
`default_nettype none

`include "addrgen_consts.svh"

module tb_addrgen;

  import addrgen_pkg::*;

  localparam int NUM_ROWS    = 7;
  localparam int POLL_LIMIT  = 2000; // status polls of two cycles each
  localparam int DRAIN_LIMIT = 200;  // cycles for the buffer to empty
  localparam int CLEAR_LIMIT = 20;

  typedef struct {
    string   name;
    addr_t   base;
    cnt_t    tot_len;
    cnt_t    d0_len;
    cnt_t    d1_len;
    cnt_t    d2_len;
    stride_t s0;
    stride_t s1;
    stride_t s2;
    stride_t s3;
    dim_en_t dim_en;
    int      ready_pct; // chance of addr_ready_i per cycle
  } row_t;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    apb_psel_i;
  logic                    apb_penable_i;
  logic                    apb_pwrite_i;
  logic [`ADDRGEN_PAW-1:0] apb_paddr_i;
  logic [`ADDRGEN_AW-1:0]  apb_pwdata_i;
  logic [`ADDRGEN_AW-1:0]  apb_prdata_o;
  logic                    apb_pready_o;
  logic                    apb_pslverr_o;
  addr_t                   addr_o;
  logic                    addr_valid_o;
  logic                    addr_ready_i;

  row_t  rows [NUM_ROWS];
  row_t  long_row;          // long run for busy and clear checks
  addr_t exp_q [$];         // model output
  addr_t got_q [$];         // monitored transfers
  int    ready_pct = 100;

  addrgen_top u_addrgen_top (.*);

  always #50 clk_i = ~clk_i;

  // random back-pressure driven 1 ns after the edge
  initial begin
    void'($urandom(32'h65e2));
    forever begin
      @(posedge clk_i);
      #1;
      addr_ready_i = (($urandom % 100) < ready_pct);
    end
  end

  // every valid and ready cycle is one transfer
  always @(posedge clk_i) begin
    if (rst_ni && addr_valid_o && addr_ready_i) begin
      got_q.push_back(addr_o);
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping on timeout");
  endtask

  // zero wait state access that returns 1 ns after the closing edge
  task automatic apb_write(input logic [`ADDRGEN_PAW-1:0] addr, input logic [31:0] data,
                           output logic err);
    apb_psel_i    = 1'b1;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = 1'b1;
    apb_paddr_i   = addr;
    apb_pwdata_i  = data;
    @(posedge clk_i);
    #1;
    apb_penable_i = 1'b1;
    @(negedge clk_i); // mid access phase
    err = apb_pslverr_o;
    check_value("apb pready on write", 32'd1, 32'(apb_pready_o));
    @(posedge clk_i);
    #1;
    apb_psel_i    = 1'b0;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input logic [`ADDRGEN_PAW-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_psel_i    = 1'b1;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = 1'b0;
    apb_paddr_i   = addr;
    @(posedge clk_i);
    #1;
    apb_penable_i = 1'b1;
    @(negedge clk_i);
    data = apb_prdata_o;
    err  = apb_pslverr_o;
    check_value("apb pready on read", 32'd1, 32'(apb_pready_o));
    @(posedge clk_i);
    #1;
    apb_psel_i    = 1'b0;
    apb_penable_i = 1'b0;
  endtask

  // program all config registers and read each one back
  task automatic configure_regs(input row_t r);
    logic [`ADDRGEN_PAW-1:0] offs [10];
    logic [31:0]             vals [10];
    logic [31:0]             rd;
    logic                    err;
    int                      i;
    offs = '{`ADDRGEN_REG_BASE, `ADDRGEN_REG_TOT_LEN, `ADDRGEN_REG_D0_LEN,
             `ADDRGEN_REG_D1_LEN, `ADDRGEN_REG_D2_LEN, `ADDRGEN_REG_D0_STRIDE,
             `ADDRGEN_REG_D1_STRIDE, `ADDRGEN_REG_D2_STRIDE, `ADDRGEN_REG_D3_STRIDE,
             `ADDRGEN_REG_DIM_EN};
    vals = '{r.base, r.tot_len, r.d0_len, r.d1_len, r.d2_len,
             r.s0, r.s1, r.s2, r.s3, 32'(r.dim_en)};
    for (i = 0; i < 10; i++) begin
      apb_write(offs[i], vals[i], err);
      check_value($sformatf("%s wr err @%h", r.name, offs[i]), 32'd0, 32'(err));
    end
    for (i = 0; i < 10; i++) begin
      apb_read(offs[i], rd, err);
      check_value($sformatf("%s rd err @%h", r.name, offs[i]), 32'd0, 32'(err));
      check_value($sformatf("%s readback @%h", r.name, offs[i]), vals[i], rd);
    end
  endtask

  // expected addresses from the four-level stepping rule
  task automatic build_expected(input row_t r);
    addr_t a0, a1, a2, a3;
    cnt_t  c0, c1, c2;
    cnt_t  n;
    exp_q.delete();
    a0 = '0;
    a1 = '0;
    a2 = '0;
    a3 = '0;
    c0 = 1;
    c1 = 1;
    c2 = 1;
    for (n = 0; n < r.tot_len; n++) begin
      exp_q.push_back(r.base + a0 + a1 + a2 + a3);
      if ((c0 < r.d0_len) || !r.dim_en[0]) begin
        a0 = a0 + r.s0;
        c0 = c0 + 1;
      end else if ((c1 < r.d1_len) || !r.dim_en[1]) begin
        a0 = '0;
        c0 = 1;
        a1 = a1 + r.s1;
        c1 = c1 + 1;
      end else if ((c2 < r.d2_len) || !r.dim_en[2]) begin
        a0 = '0;
        c0 = 1;
        a1 = '0;
        c1 = 1;
        a2 = a2 + r.s2;
        c2 = c2 + 1;
      end else begin
        a0 = '0;
        c0 = 1;
        a1 = '0;
        c1 = 1;
        a2 = '0;
        c2 = 1;
        a3 = a3 + r.s3; // outermost level never wraps
      end
    end
  endtask

  task automatic start_run(input string name);
    logic err;
    got_q.delete();
    apb_write(`ADDRGEN_REG_CTRL, 32'd1 << `ADDRGEN_CTRL_START_BIT, err);
    check_value({name, " start err"}, 32'd0, 32'(err));
  endtask

  // start and wait for done and drain before comparing
  task automatic run_and_compare(input string name);
    logic [31:0] status;
    logic        err;
    int          polls;
    int          cycles;
    int          i;
    start_run(name);
    polls = 0;
    apb_read(`ADDRGEN_REG_STATUS, status, err);
    while (!status[`ADDRGEN_STATUS_DONE_BIT] && polls < POLL_LIMIT) begin
      apb_read(`ADDRGEN_REG_STATUS, status, err);
      polls++;
    end
    if (!status[`ADDRGEN_STATUS_DONE_BIT]) report_timeout({name, " done status"});
    cycles = 0;
    while (addr_valid_o && cycles < DRAIN_LIMIT) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (addr_valid_o) report_timeout({name, " address stream to drain"});
    check_value({name, " count"}, exp_q.size(), got_q.size());
    for (i = 0; i < exp_q.size(); i++) begin
      check_value($sformatf("%s addr[%0d]", name, i), exp_q[i], got_q[i]);
    end
    apb_read(`ADDRGEN_REG_STATUS, status, err);
    check_value({name, " status"}, 32'd1 << `ADDRGEN_STATUS_DONE_BIT, status);
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    int          r;
    int          cycles;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    apb_psel_i    = 1'b0;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = 1'b0;
    apb_paddr_i   = '0;
    apb_pwdata_i  = '0;
    addr_ready_i  = 1'b1;

    //         name                base          tot  d0 d1 d2  s0    s1      s2      s3
    rows[0] = '{"flat_000",        32'h0000_1000, 8,  3, 2, 2,  4,    'h100,  'h1000, 'h10000,
                3'b000, 100};
    rows[1] = '{"wrap_d0_001",     32'h0000_2000, 12, 4, 2, 2,  4,    'h40,   'h400,  'h4000,
                3'b001, 100};
    rows[2] = '{"wrap_d1_011_neg", 32'h0000_8000, 18, 3, 2, 2,  -4,   'h20,   -'h100, 'h4000,
                3'b011, 100};
    rows[3] = '{"full_111",        32'h0000_0000, 30, 2, 3, 2,  8,    'h80,   'h800,  -'h10,
                3'b111, 100};
    rows[4] = '{"backpressure_111", 32'h4000_0000, 40, 2, 3, 2, 8,    'h80,   'h800,  -'h10,
                3'b111, 40};
    rows[5] = '{"backpressure_neg", 32'h0000_0010, 25, 4, 3, 2, -8,   -'h40,  'h200,  'h2000,
                3'b011, 25};
    rows[6] = '{"zero_len",        32'h0000_3000, 0,  2, 2, 2,  4,    'h10,   'h100,  'h1000,
                3'b111, 100};
    long_row = '{"busy_clear",     32'h0100_0000, 300, 5, 4, 3, 4,   'h40,   'h400,  -'h1000,
                 3'b111, 50};

    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;

    // unmapped offsets
    apb_read(12'h030, rd, err);
    check_value("unmapped read pslverr", 32'd1, 32'(err));
    apb_write(12'h0FC, 32'h1234_5678, err);
    check_value("unmapped write pslverr", 32'd1, 32'(err));

    for (r = 0; r < NUM_ROWS; r++) begin
      configure_regs(rows[r]);
      build_expected(rows[r]);
      ready_pct = rows[r].ready_pct;
      run_and_compare(rows[r].name);
    end

    // config writes rejected mid-run
    configure_regs(long_row);
    build_expected(long_row);
    ready_pct = long_row.ready_pct;
    start_run(long_row.name);
    apb_read(`ADDRGEN_REG_STATUS, rd, err);
    check_value("busy_clear busy", 32'd1, 32'(rd[`ADDRGEN_STATUS_BUSY_BIT]));
    apb_write(`ADDRGEN_REG_BASE, 32'hDEAD_0000, err);
    check_value("busy_clear write pslverr", 32'd1, 32'(err));
    apb_read(`ADDRGEN_REG_BASE, rd, err);
    check_value("busy_clear base kept", long_row.base, rd);

    // clear mid-run
    apb_write(`ADDRGEN_REG_CTRL, 32'd1 << `ADDRGEN_CTRL_CLEAR_BIT, err);
    check_value("busy_clear clear err", 32'd0, 32'(err));
    cycles = 0;
    while (addr_valid_o && cycles < CLEAR_LIMIT) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (addr_valid_o) report_timeout("addr_valid_o to fall after clear");
    check_value("busy_clear partial", 32'd1, 32'(got_q.size() < long_row.tot_len));
    apb_read(`ADDRGEN_REG_STATUS, rd, err);
    check_value("busy_clear status after clear", 32'd0, rd);

    // restart replays from the first address
    run_and_compare({long_row.name, " replay"});

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/addrgen_pkg.sv
source/addrgen_apb_regs.sv
source/addrgen_loop_nest.sv
source/addrgen_out_buf.sv
source/addrgen_top.sv
verification/tb_addrgen.sv
